/* mem_init.hex */
// One 256-bit line per row, word 7 first; rows 0-15 left block, rows 16-31 right block
5a0007ff5a0006ff5a0005ff5a0004ff5a0003ff5a0002ff5a0001ff5a0000ff
5a0107fe5a0106fe5a0105fe5a0104fe5a0103fe5a0102fe5a0101fe5a0100fe
5a0207fd5a0206fd5a0205fd5a0204fd5a0203fd5a0202fd5a0201fd5a0200fd
5a0307fc5a0306fc5a0305fc5a0304fc5a0303fc5a0302fc5a0301fc5a0300fc
5a0407fb5a0406fb5a0405fb5a0404fb5a0403fb5a0402fb5a0401fb5a0400fb
5a0507fa5a0506fa5a0505fa5a0504fa5a0503fa5a0502fa5a0501fa5a0500fa
5a0607f95a0606f95a0605f95a0604f95a0603f95a0602f95a0601f95a0600f9
5a0707f85a0706f85a0705f85a0704f85a0703f85a0702f85a0701f85a0700f8
5a0807f75a0806f75a0805f75a0804f75a0803f75a0802f75a0801f75a0800f7
5a0907f65a0906f65a0905f65a0904f65a0903f65a0902f65a0901f65a0900f6
5a0a07f55a0a06f55a0a05f55a0a04f55a0a03f55a0a02f55a0a01f55a0a00f5
5a0b07f45a0b06f45a0b05f45a0b04f45a0b03f45a0b02f45a0b01f45a0b00f4
5a0c07f35a0c06f35a0c05f35a0c04f35a0c03f35a0c02f35a0c01f35a0c00f3
5a0d07f25a0d06f25a0d05f25a0d04f25a0d03f25a0d02f25a0d01f25a0d00f2
5a0e07f15a0e06f15a0e05f15a0e04f15a0e03f15a0e02f15a0e01f15a0e00f1
5a0f07f05a0f06f05a0f05f05a0f04f05a0f03f05a0f02f05a0f01f05a0f00f0
5b1007ef5b1006ef5b1005ef5b1004ef5b1003ef5b1002ef5b1001ef5b1000ef
5b1107ee5b1106ee5b1105ee5b1104ee5b1103ee5b1102ee5b1101ee5b1100ee
5b1207ed5b1206ed5b1205ed5b1204ed5b1203ed5b1202ed5b1201ed5b1200ed
5b1307ec5b1306ec5b1305ec5b1304ec5b1303ec5b1302ec5b1301ec5b1300ec
5b1407eb5b1406eb5b1405eb5b1404eb5b1403eb5b1402eb5b1401eb5b1400eb
5b1507ea5b1506ea5b1505ea5b1504ea5b1503ea5b1502ea5b1501ea5b1500ea
5b1607e95b1606e95b1605e95b1604e95b1603e95b1602e95b1601e95b1600e9
5b1707e85b1706e85b1705e85b1704e85b1703e85b1702e85b1701e85b1700e8
5b1807e75b1806e75b1805e75b1804e75b1803e75b1802e75b1801e75b1800e7
5b1907e65b1906e65b1905e65b1904e65b1903e65b1902e65b1901e65b1900e6
5b1a07e55b1a06e55b1a05e55b1a04e55b1a03e55b1a02e55b1a01e55b1a00e5
5b1b07e45b1b06e45b1b05e45b1b04e45b1b03e45b1b02e45b1b01e45b1b00e4
5b1c07e35b1c06e35b1c05e35b1c04e35b1c03e35b1c02e35b1c01e35b1c00e3
5b1d07e25b1d06e25b1d05e25b1d04e25b1d03e25b1d02e25b1d01e25b1d00e2
5b1e07e15b1e06e15b1e05e15b1e04e15b1e03e15b1e02e15b1e01e15b1e00e1
5b1f07e05b1f06e05b1f05e05b1f04e05b1f03e05b1f02e05b1f01e05b1f00e0

/* files.f */
logic/axi_mem_pkg.sv
logic/rd_ctrl_fsm.sv
logic/latency_timer.sv
logic/burst_beat_gen.sv
logic/line_store.sv
logic/axi_mem_responder.sv
tb/tb_axi_mem_sva.sv
tb/tb_axi_mem.sv

/* run.sh */
#!/bin/sh
# Build the responder and its testbench with Verilator, run the
# simulation and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_mem -f files.f \
    && ./obj_dir/Vtb_axi_mem | tee /dev/stderr | grep -q -F '** PASS **' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb/tb_axi_mem.sv */
// Testbench for the AXI4 read-only GFP8 memory responder
// Issues INCR read bursts, stalls rready from an LFSR and checks every
// R beat against a private copy of the preload image

`default_nettype none

module tb_axi_mem
    import axi_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    // Bursts issued by the main sequence
    localparam int NUM_BURSTS = 17;
    localparam int MAX_BEATS  = 16;
    localparam int WATCHDOG_CYCLES = 2 * NUM_BURSTS * (MAX_BEATS + READ_LATENCY_CYCLES + 10);

    logic                  i_clk = 1'b0;
    logic                  i_reset_n;
    logic                  i_arvalid;
    logic [ADDR_WIDTH-1:0] i_araddr;
    logic [ID_WIDTH-1:0]   i_arid;
    logic [LEN_WIDTH-1:0]  i_arlen;
    logic [SIZE_WIDTH-1:0] i_arsize;
    logic                  o_arready;
    logic                  o_rvalid;
    logic [DATA_WIDTH-1:0] o_rdata;
    logic [ID_WIDTH-1:0]   o_rid;
    logic [1:0]            o_rresp;
    logic                  o_rlast;
    logic                  i_rready;

    // Private copy of the preload image
    logic [DATA_WIDTH-1:0] ref_mem [0:MEM_LINES-1];

    // Expected beats, oldest first
    logic [DATA_WIDTH-1:0] exp_data_q [$];
    logic [ID_WIDTH-1:0]   exp_id_q [$];
    logic                  exp_last_q [$];

    logic [31:0] lfsr_state = 32'hdc42;
    logic        stall_en = 1'b0;

    axi_mem_responder i_dut (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_arvalid (i_arvalid),
        .i_araddr  (i_araddr),
        .i_arid    (i_arid),
        .i_arlen   (i_arlen),
        .i_arsize  (i_arsize),
        .o_arready (o_arready),
        .o_rvalid  (o_rvalid),
        .o_rdata   (o_rdata),
        .o_rid     (o_rid),
        .o_rresp   (o_rresp),
        .o_rlast   (o_rlast),
        .i_rready  (i_rready)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [ADDR_WIDTH-1:0] line_addr(input int line);
        return ADDR_WIDTH'(line) << 5;
    endfunction

    // Line index is byte address bits 30:5 cut to 16 bits, so 20:5
    function automatic logic [DATA_WIDTH-1:0] expected_line(
        input logic [ADDR_WIDTH-1:0] base,
        input int                    beat,
        input int                    size
    );
        logic [ADDR_WIDTH-1:0] addr;
        logic [15:0]           idx;
        addr = base + (ADDR_WIDTH'(beat) << size);
        idx  = addr[20:5];
        if (int'(idx) < MEM_LINES) begin
            return ref_mem[idx[4:0]];
        end
        // Past the end of memory reads as zero
        return '0;
    endfunction

    task automatic report_failure(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // AR handshake, expected beats are queued at the acknowledge
    task automatic read_burst(
        input logic [ID_WIDTH-1:0]   id,
        input logic [ADDR_WIDTH-1:0] addr,
        input int                    len,
        input int                    size
    );
        int beat;
        @(posedge i_clk);
        #1;
        i_arvalid = 1'b1;
        i_araddr  = addr;
        i_arid    = id;
        i_arlen   = LEN_WIDTH'(len);
        i_arsize  = SIZE_WIDTH'(size);
        do @(negedge i_clk); while (!o_arready);
        assert (exp_data_q.size() == 0)
            else report_failure("address accepted while a burst was still open");
        for (beat = 0; beat <= len; beat++) begin
            exp_data_q.push_back(expected_line(addr, beat, size));
            exp_id_q.push_back(id);
            exp_last_q.push_back(beat == len);
        end
        @(posedge i_clk);
        #1;
        i_arvalid = 1'b0;
    endtask

    // Returns on a falling edge once every beat has gone
    task automatic wait_drained();
        do @(negedge i_clk); while (exp_data_q.size() != 0 || o_rvalid);
    endtask

    task automatic random_burst(input logic [ID_WIDTH-1:0] id, input int size);
        logic [31:0] len_bits;
        logic [31:0] line_bits;
        take_bits(4, len_bits);
        take_bits(5, line_bits);
        read_burst(id, line_addr(int'(line_bits[4:0])), int'(len_bits[3:0]), size);
        wait_drained();
    endtask

    // ======================================================================
    // R channel master and beat checks
    // ======================================================================
    initial begin
        logic [31:0] stall_bits;
        i_rready = 1'b1;
        forever begin
            @(posedge i_clk);
            #1;
            if (stall_en) begin
                take_bits(1, stall_bits);
                i_rready = stall_bits[0];
            end else begin
                i_rready = 1'b1;
            end
        end
    end

    // Inputs and outputs are both settled at the falling edge
    always @(negedge i_clk) begin
        assert (i_dut.u_sva.assert_failures == 0)
            else report_failure("bound protocol assertion failed");
        if (i_reset_n && o_rvalid && i_rready) begin
            assert (exp_data_q.size() != 0)
                else report_failure("beat delivered beyond the requested length");
            assert (o_rdata == exp_data_q[0])
                else report_failure($sformatf("rdata %h, expected %h", o_rdata, exp_data_q[0]));
            assert (o_rid == exp_id_q[0])
                else report_failure($sformatf("rid %h, expected %h", o_rid, exp_id_q[0]));
            assert (o_rlast == exp_last_q[0])
                else report_failure($sformatf("rlast %b, expected %b", o_rlast, exp_last_q[0]));
            assert (o_rresp == 2'b00)
                else report_failure($sformatf("rresp %b, expected OKAY", o_rresp));
            void'(exp_data_q.pop_front());
            void'(exp_id_q.pop_front());
            void'(exp_last_q.pop_front());
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the responder did not finish all bursts in time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        int n;
        i_reset_n = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arid    = '0;
        i_arlen   = '0;
        i_arsize  = '0;
        $readmemh("mem_init.hex", ref_mem);
        repeat (2) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        @(negedge i_clk);
        assert (!o_arready && !o_rvalid)
            else report_failure("arready or rvalid high after reset");

        // Single beats, one line in each block
        read_burst(8'h11, line_addr(3), 0, 5);
        wait_drained();
        read_burst(8'h22, line_addr(20), 0, 5);
        wait_drained();
        // Full length bursts over each block
        read_burst(8'h33, line_addr(0), 15, 5);
        wait_drained();
        read_burst(8'h44, line_addr(16), 15, 5);
        wait_drained();
        // Half line steps, each line twice
        read_burst(8'h55, line_addr(4), 7, 4);
        wait_drained();
        for (n = 0; n < 3; n++) begin
            random_burst(ID_WIDTH'(8'h60 + n), 5);
        end

        // Random rready stalls
        stall_en = 1'b1;
        for (n = 0; n < 4; n++) begin
            random_burst(ID_WIDTH'(8'h70 + n), 4 + (n % 2));
        end
        stall_en = 1'b0;

        // Out of range lines and truncated high address bits
        read_burst(8'h81, line_addr(40), 3, 5);
        wait_drained();
        read_burst(8'h82, line_addr(30), 3, 5);
        wait_drained();
        read_burst(8'h83, (42'h1 << 35) | (42'h1 << 21), 1, 5);
        wait_drained();

        // Second request held high through a running burst
        read_burst(8'h91, line_addr(8), 15, 5);
        read_burst(8'h92, line_addr(24), 2, 5);
        wait_drained();
        // A few idle cycles to catch stray beats
        repeat (5) @(negedge i_clk);

        if (i_dut.u_sva.assert_failures == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            report_failure("bound protocol assertions failed during the run");
        end
    end

endmodule : tb_axi_mem

`default_nettype wire

/* tb/tb_axi_mem_sva.sv */
// Protocol assertions for the AXI4 read responder ports
// R channel held under back-pressure, single cycle arready and no
// address acknowledge while a burst is open

`default_nettype none

module tb_axi_mem_sva
    import axi_mem_pkg::*;
(
    input wire                  i_clk,
    input wire                  i_reset_n,
    input wire                  o_arready,
    input wire                  o_rvalid,
    input wire [DATA_WIDTH-1:0] o_rdata,
    input wire [ID_WIDTH-1:0]   o_rid,
    input wire [1:0]            o_rresp,
    input wire                  o_rlast,
    input wire                  i_rready
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned assert_failures = 0;
    logic        in_burst;

    // Open from the acknowledge until the rlast beat transfers
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            in_burst <= 1'b0;
        end else if (o_arready) begin
            in_burst <= 1'b1;
        end else if (o_rvalid && i_rready && o_rlast) begin
            in_burst <= 1'b0;
        end
    end

    // ======================================================================
    // Properties
    // ======================================================================
    r_held_while_stalled: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata) && $stable(o_rid)
                                     && $stable(o_rlast) && $stable(o_rresp)))
        else begin
            $error("R channel changed while stalled");
            assert_failures++;
        end

    arready_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_arready |=> !o_arready)
        else begin
            $error("arready high for more than one cycle");
            assert_failures++;
        end

    no_ack_in_burst: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        in_burst |-> !o_arready)
        else begin
            $error("arready high during an open burst");
            assert_failures++;
        end

endmodule : tb_axi_mem_sva

bind axi_mem_responder tb_axi_mem_sva u_sva (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .o_rdata   (o_rdata),
    .o_rid     (o_rid),
    .o_rresp   (o_rresp),
    .o_rlast   (o_rlast),
    .i_rready  (i_rready)
);

`default_nettype wire

/* logic/axi_mem_responder.sv */
// AXI4 read-only responder for two GFP8 matrix blocks
// One INCR burst at a time, fixed latency, OKAY responses

`default_nettype none

module axi_mem_responder
    import axi_mem_pkg::*;
(
    input  wire                   i_clk,
    input  wire                   i_reset_n,

    // AR channel
    input  wire                   i_arvalid,
    input  wire  [ADDR_WIDTH-1:0] i_araddr,
    input  wire  [ID_WIDTH-1:0]   i_arid,
    input  wire  [LEN_WIDTH-1:0]  i_arlen,
    input  wire  [SIZE_WIDTH-1:0] i_arsize,
    output logic                  o_arready,

    // R channel
    output logic                  o_rvalid,
    output logic [DATA_WIDTH-1:0] o_rdata,
    output logic [ID_WIDTH-1:0]   o_rid,
    output logic [1:0]            o_rresp,
    output logic                  o_rlast,
    input  wire                   i_rready
);

    // Controller strobes
    logic capture;
    logic timer_start;
    logic timer_done;
    logic data_phase;
    logic last_accepted;

    // Beat path
    logic                       advance;
    logic                       beat;
    logic [LINE_ADDR_WIDTH-1:0] line_idx;
    logic                       in_range;
    logic                       beat_last;

    // ==================================================================
    // Control
    // ==================================================================
    rd_ctrl_fsm u_ctrl (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_arvalid       (i_arvalid),
        .i_timer_done    (timer_done),
        .i_last_accepted (last_accepted),
        .o_arready       (o_arready),
        .o_capture       (capture),
        .o_timer_start   (timer_start),
        .o_data_phase    (data_phase)
    );

    latency_timer u_timer (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_start   (timer_start),
        .o_done    (timer_done)
    );

    // ==================================================================
    // Data path
    // ==================================================================
    burst_beat_gen u_beats (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_capture    (capture),
        .i_araddr     (i_araddr),
        .i_arid       (i_arid),
        .i_arlen      (i_arlen),
        .i_arsize     (i_arsize),
        .i_data_phase (data_phase),
        .i_advance    (advance),
        .o_beat       (beat),
        .o_line_idx   (line_idx),
        .o_in_range   (in_range),
        .o_last       (beat_last),
        .o_rid        (o_rid)
    );

    line_store u_store (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_beat          (beat),
        .i_line_idx      (line_idx),
        .i_in_range      (in_range),
        .i_last          (beat_last),
        .i_rready        (i_rready),
        .o_advance       (advance),
        .o_last_accepted (last_accepted),
        .o_rvalid        (o_rvalid),
        .o_rdata         (o_rdata),
        .o_rlast         (o_rlast)
    );

    // Every beat is OKAY, out of range included
    assign o_rresp = RESP_OKAY;

endmodule : axi_mem_responder

`default_nettype wire

/* logic/line_store.sv */
// Preloaded GFP8 line store
// Reads the addressed line into a one-deep output register with
// valid and last, zero filling lines past the end of memory

`default_nettype none

module line_store
    import axi_mem_pkg::*;
(
    input  wire                        i_clk,
    input  wire                        i_reset_n,
    input  wire                        i_beat,
    input  wire  [LINE_ADDR_WIDTH-1:0] i_line_idx,
    input  wire                        i_in_range,
    input  wire                        i_last,
    input  wire                        i_rready,
    output logic                       o_advance,
    output logic                       o_last_accepted,
    output logic                       o_rvalid,
    output logic [DATA_WIDTH-1:0]      o_rdata,
    output logic                       o_rlast
);

    // Left block in lines 0..15, right block in 16..31
    logic [DATA_WIDTH-1:0] mem [0:MEM_LINES-1];

    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    // ==================================================================
    // Output register
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (i_beat) begin
            o_rdata <= i_in_range ? mem[i_line_idx[MEM_IDX_WIDTH-1:0]] : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_rvalid <= 1'b0;
            o_rlast  <= 1'b0;
        end else if (i_beat) begin
            o_rvalid <= 1'b1;
            o_rlast  <= i_last;
        end else if (i_rready) begin
            // Taken with nothing behind it
            o_rvalid <= 1'b0;
        end
    end

    // Room for a new beat when empty or draining this cycle
    assign o_advance       = !o_rvalid || i_rready;
    assign o_last_accepted = o_rvalid && i_rready && o_rlast;

endmodule : line_store

`default_nettype wire

/* logic/burst_beat_gen.sv */
// INCR burst beat generator
// Holds the captured AR fields, counts beats and forms the byte and
// line address of each beat, with range and last-beat flags

`default_nettype none

module burst_beat_gen
    import axi_mem_pkg::*;
(
    input  wire                        i_clk,
    input  wire                        i_reset_n,
    input  wire                        i_capture,
    input  wire  [ADDR_WIDTH-1:0]      i_araddr,
    input  wire  [ID_WIDTH-1:0]        i_arid,
    input  wire  [LEN_WIDTH-1:0]       i_arlen,
    input  wire  [SIZE_WIDTH-1:0]      i_arsize,
    input  wire                        i_data_phase,
    input  wire                        i_advance,
    output logic                       o_beat,
    output logic [LINE_ADDR_WIDTH-1:0] o_line_idx,
    output logic                       o_in_range,
    output logic                       o_last,
    output logic [ID_WIDTH-1:0]        o_rid
);

    // Captured AR fields
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ID_WIDTH-1:0]   id_q;
    logic [LEN_WIDTH-1:0]  len_q;
    logic [SIZE_WIDTH-1:0] size_q;

    // Burst progress
    logic [LEN_WIDTH-1:0]  beat_cnt;
    logic                  last_issued;
    logic [ADDR_WIDTH-1:0] byte_addr;

    // ==================================================================
    // AR capture
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            addr_q <= i_araddr;
            id_q   <= i_arid;
            len_q  <= i_arlen;
            size_q <= i_arsize;
        end
    end

    // ==================================================================
    // Beat counter
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            beat_cnt    <= '0;
            last_issued <= 1'b0;
        end else if (i_capture) begin
            beat_cnt    <= '0;
            last_issued <= 1'b0;
        end else if (o_beat) begin
            // Counter parks on the final beat
            if (o_last) begin
                last_issued <= 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // One beat per advance, never past arlen
    assign o_beat = i_data_phase && i_advance && !last_issued;
    assign o_last = (beat_cnt == len_q);

    // INCR address, step of 1 << arsize bytes
    assign byte_addr = addr_q + (ADDR_WIDTH'(beat_cnt) << size_q);

    // Line index from bits 30:5, kept to its low 16 bits
    assign o_line_idx = byte_addr[LINE_OFFSET_BITS +: LINE_ADDR_WIDTH];
    assign o_in_range = (o_line_idx < LINE_ADDR_WIDTH'(MEM_LINES));

    assign o_rid = id_q;

endmodule : burst_beat_gen

`default_nettype wire

/* logic/latency_timer.sv */
// Read latency timer
// Cleared by a start pulse, then counts up to the modelled latency
// and holds done until the next start

`default_nettype none

module latency_timer
    import axi_mem_pkg::*;
(
    input  wire  i_clk,
    input  wire  i_reset_n,
    input  wire  i_start,
    output logic o_done
);

    logic [TIMER_WIDTH-1:0] count;
    logic                   running;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (i_start) begin
            // Restart from zero, any old done is dropped
            count   <= '0;
            running <= 1'b1;
        end else if (running && !o_done) begin
            count <= count + 1'b1;
        end
    end

    // Count freezes at the limit, so done stays up
    assign o_done = running && (count == TIMER_WIDTH'(READ_LATENCY_CYCLES));

endmodule : latency_timer

`default_nettype wire

/* logic/rd_ctrl_fsm.sv */
// Read burst controller
// Sequences address capture and acknowledge, the latency wait and the
// data phase, returning to idle once the last beat has been taken

`default_nettype none

module rd_ctrl_fsm (
    input  wire  i_clk,
    input  wire  i_reset_n,
    input  wire  i_arvalid,
    input  wire  i_timer_done,
    input  wire  i_last_accepted,
    output logic o_arready,
    output logic o_capture,
    output logic o_timer_start,
    output logic o_data_phase
);

    // State encodings
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_ACK     = 2'd1;
    localparam logic [1:0] ST_LATENCY = 2'd2;
    localparam logic [1:0] ST_DATA    = 2'd3;

    logic [1:0] state;
    logic [1:0] state_next;

    // ==================================================================
    // State register
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ==================================================================
    // Next state
    // ==================================================================
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_arvalid) begin
                    state_next = ST_ACK;
                end
            end
            // Single acknowledge cycle, timer armed here
            ST_ACK: begin
                state_next = ST_LATENCY;
            end
            ST_LATENCY: begin
                if (i_timer_done) begin
                    state_next = ST_DATA;
                end
            end
            // Stay until the rlast beat transfers
            ST_DATA: begin
                if (i_last_accepted) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // Fields are taken the first cycle arvalid is seen in idle
    assign o_capture     = (state == ST_IDLE) && i_arvalid;
    assign o_arready     = (state == ST_ACK);
    assign o_timer_start = (state == ST_ACK);
    assign o_data_phase  = (state == ST_DATA);

endmodule : rd_ctrl_fsm

`default_nettype wire

/* logic/axi_mem_pkg.sv */
// AXI4 read-only GFP8 memory responder shared definitions
// Bus widths, memory geometry, latency and response codes

`default_nettype none

package axi_mem_pkg;

    // ==================================================================
    // AXI4 read channel widths
    // ==================================================================
    localparam int DATA_WIDTH = 256;
    // GDDR6 NoC style byte address
    localparam int ADDR_WIDTH = 42;
    localparam int ID_WIDTH   = 8;
    localparam int LEN_WIDTH  = 8;
    localparam int SIZE_WIDTH = 3;

    // ==================================================================
    // Memory geometry
    // ==================================================================
    // Two GFP8 blocks, left then right
    localparam int LINES_PER_BLOCK  = 16;
    localparam int NUM_BLOCKS       = 2;
    localparam int MEM_LINES        = LINES_PER_BLOCK * NUM_BLOCKS;
    localparam int MEM_IDX_WIDTH    = $clog2(MEM_LINES);
    // 32 bytes per 256-bit line
    localparam int LINE_OFFSET_BITS = 5;
    localparam int LINE_ADDR_WIDTH  = 16;

    // Modelled read latency in clock cycles
    localparam int READ_LATENCY_CYCLES = 2;
    localparam int TIMER_WIDTH         = $clog2(READ_LATENCY_CYCLES + 1);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Preload image, left block lines first
    localparam string MEM_INIT_FILE = "mem_init.hex";

endpackage : axi_mem_pkg

`default_nettype wire
